// ==== rv64_decode_macros.svh ====
`ifndef RV64_DECODE_MACROS_SVH
`define RV64_DECODE_MACROS_SVH

// instruction word width
`define INST_W 32

// register data width, also the immediate width
`define XLEN 64

// architectural register index width
`define REG_IDX_W 5

// opcode field position in the instruction word
`define OPC_MSB 6
`define OPC_LSB 0

`endif

// ==== rv64_decode_pkg.sv ====
`include "rv64_decode_macros.svh"

package rv64_decode_pkg;

  // major opcode groups taken from inst[6:0]
  typedef enum logic [3:0] {
    OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JALR, OPC_JAL,
    OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32,
    OPC_AUIPC, OPC_LUI, OPC_SYSTEM, OPC_OTHER
  } opc_class_e;

  // operand layout of the word
  typedef enum logic [2:0] {
    FMT_NONE, FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J
  } inst_fmt_e;

  typedef enum logic [4:0] {
    ALU_NONE = 5'd0,
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_AND, ALU_OR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  // access width and signedness for loads and stores
  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,
    MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_LWU, MEM_LD,
    MEM_SB, MEM_SH, MEM_SW, MEM_SD
  } mem_op_e;

  typedef enum logic [3:0] {
    EXC_NONE = 4'd0,
    EXC_AUIPC, EXC_LUI, EXC_JAL, EXC_JALR, EXC_LOAD, EXC_STORE,
    EXC_BRANCH, EXC_OPIMM, EXC_OPIMM32, EXC_OP, EXC_OP32, EXC_EBREAK
  } exc_op_e;

  // next pc selection
  typedef enum logic [1:0] {
    PC_INC4, PC_BRANCH, PC_JAL, PC_JALR
  } pc_op_e;

  typedef struct packed {
    logic [`REG_IDX_W-1:0] rs1;
    logic [`REG_IDX_W-1:0] rs2;
    logic [`REG_IDX_W-1:0] rd;
  } reg_idx_t;

  // full bundle handed to execute
  typedef struct packed {
    reg_idx_t          regs;
    logic [`XLEN-1:0]  imm;
    alu_op_e           alu_op;
    mem_op_e           mem_op;
    exc_op_e           exc_op;
    pc_op_e            pc_op;
  } decoded_t;

endpackage

// ==== inst_classify.sv ====
`timescale 1ns/1ps
`include "rv64_decode_macros.svh"

module inst_classify import rv64_decode_pkg::*; (
  input  logic [`INST_W-1:0] inst,
  output opc_class_e         opc_class,
  output inst_fmt_e          fmt,
  output exc_op_e            exc_op,
  output pc_op_e             pc_op
);

  logic is_ebreak;

  // standard rv64 major opcodes
  always_comb begin
    case (inst[`OPC_MSB:`OPC_LSB])
      7'b0000011: opc_class = OPC_LOAD;
      7'b0100011: opc_class = OPC_STORE;
      7'b1100011: opc_class = OPC_BRANCH;
      7'b1100111: opc_class = OPC_JALR;
      7'b1101111: opc_class = OPC_JAL;
      7'b0010011: opc_class = OPC_OP_IMM;
      7'b0011011: opc_class = OPC_OP_IMM_32;
      7'b0110011: opc_class = OPC_OP;
      7'b0111011: opc_class = OPC_OP_32;
      7'b0010111: opc_class = OPC_AUIPC;
      7'b0110111: opc_class = OPC_LUI;
      7'b1110011: opc_class = OPC_SYSTEM;
      default:    opc_class = OPC_OTHER;
    endcase
  end

  // func3 zero and imm field of one
  assign is_ebreak = (opc_class == OPC_SYSTEM) && (inst[14:12] == 3'b000) &&
                     (inst[31:20] == 12'd1);

  always_comb begin
    fmt    = FMT_NONE;
    pc_op  = PC_INC4;
    exc_op = EXC_NONE;
    case (opc_class)
      OPC_LOAD:      begin fmt = FMT_I; exc_op = EXC_LOAD;    end
      OPC_STORE:     begin fmt = FMT_S; exc_op = EXC_STORE;   end
      OPC_OP_IMM:    begin fmt = FMT_I; exc_op = EXC_OPIMM;   end
      OPC_OP_IMM_32: begin fmt = FMT_I; exc_op = EXC_OPIMM32; end
      OPC_OP:        begin fmt = FMT_R; exc_op = EXC_OP;      end
      OPC_OP_32:     begin fmt = FMT_R; exc_op = EXC_OP32;    end
      OPC_AUIPC:     begin fmt = FMT_U; exc_op = EXC_AUIPC;   end
      OPC_LUI:       begin fmt = FMT_U; exc_op = EXC_LUI;     end
      OPC_BRANCH:    begin fmt = FMT_B; exc_op = EXC_BRANCH; pc_op = PC_BRANCH; end
      OPC_JAL:       begin fmt = FMT_J; exc_op = EXC_JAL;    pc_op = PC_JAL;    end
      OPC_JALR:      begin fmt = FMT_I; exc_op = EXC_JALR;   pc_op = PC_JALR;   end
      default:       ;
    endcase
    // ebreak wins over everything else
    if (is_ebreak) begin
      exc_op = EXC_EBREAK;
    end
  end

endmodule

// ==== operand_extract.sv ====
`timescale 1ns/1ps
`include "rv64_decode_macros.svh"

module operand_extract import rv64_decode_pkg::*; (
  input  logic [`INST_W-1:0] inst,
  input  inst_fmt_e          fmt,
  output reg_idx_t           regs,
  output logic [`XLEN-1:0]   imm
);

  logic use_rs1;
  logic use_rs2;
  logic use_rd;

  // which index fields the format actually carries
  assign use_rs1 = (fmt == FMT_R) || (fmt == FMT_I) || (fmt == FMT_S) || (fmt == FMT_B);
  assign use_rs2 = (fmt == FMT_R) || (fmt == FMT_S) || (fmt == FMT_B);
  assign use_rd  = (fmt == FMT_R) || (fmt == FMT_I) || (fmt == FMT_U) || (fmt == FMT_J);

  assign regs.rs1 = use_rs1 ? inst[19:15] : '0;
  assign regs.rs2 = use_rs2 ? inst[24:20] : '0;
  assign regs.rd  = use_rd  ? inst[11:7]  : '0;

  // sign bit is always inst[31]
  always_comb begin
    case (fmt)
      FMT_I: imm = {{(`XLEN-11){inst[31]}}, inst[30:20]};
      FMT_S: imm = {{(`XLEN-11){inst[31]}}, inst[30:25], inst[11:7]};
      FMT_B: imm = {{(`XLEN-12){inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      FMT_U: imm = {{(`XLEN-31){inst[31]}}, inst[30:12], 12'b0};
      FMT_J: begin
        imm = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: imm = '0;
    endcase
  end

endmodule

// ==== op_decode.sv ====
`timescale 1ns/1ps
`include "rv64_decode_macros.svh"

module op_decode import rv64_decode_pkg::*; (
  input  logic [`INST_W-1:0] inst,
  input  opc_class_e         opc_class,
  output alu_op_e            alu_op,
  output mem_op_e            mem_op
);

  logic [2:0] func3;
  logic [6:0] func7;
  logic       f7_zero;
  logic       f7_alt;

  assign func3   = inst[14:12];
  assign func7   = inst[31:25];
  assign f7_zero = (func7 == 7'b0000000);
  assign f7_alt  = (func7 == 7'b0100000);

  always_comb begin
    alu_op = ALU_NONE;
    case (opc_class)
      OPC_LOAD, OPC_STORE, OPC_JAL, OPC_AUIPC: alu_op = ALU_ADD;
      OPC_JALR: if (func3 == 3'b000) alu_op = ALU_ADD;
      OPC_BRANCH: begin
        case (func3)
          3'b000:  alu_op = ALU_BEQ;
          3'b001:  alu_op = ALU_BNE;
          3'b100:  alu_op = ALU_BLT;
          3'b101:  alu_op = ALU_BGE;
          3'b110:  alu_op = ALU_BLTU;
          3'b111:  alu_op = ALU_BGEU;
          default: alu_op = ALU_NONE;
        endcase
      end
      OPC_OP_IMM: begin
        // rv64 shamt is six bits, so only func7[6:1] is checked
        case (func3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: if (func7[6:1] == 6'b000000) alu_op = ALU_SLL;
          3'b101: begin
            if (func7[6:1] == 6'b000000) alu_op = ALU_SRL;
            else if (func7[6:1] == 6'b010000) alu_op = ALU_SRA;
          end
          default: alu_op = ALU_NONE;
        endcase
      end
      OPC_OP_IMM_32: begin
        case (func3)
          3'b000: alu_op = ALU_ADD;
          3'b001: if (f7_zero) alu_op = ALU_SLL;
          3'b101: alu_op = f7_zero ? ALU_SRL : (f7_alt ? ALU_SRA : ALU_NONE);
          default: alu_op = ALU_NONE;
        endcase
      end
      OPC_OP, OPC_OP_32: begin
        // the word forms have no compare or logic ops
        case (func3)
          3'b000: alu_op = f7_zero ? ALU_ADD : (f7_alt ? ALU_SUB : ALU_NONE);
          3'b001: if (f7_zero) alu_op = ALU_SLL;
          3'b101: alu_op = f7_zero ? ALU_SRL : (f7_alt ? ALU_SRA : ALU_NONE);
          3'b010: if (f7_zero && opc_class == OPC_OP) alu_op = ALU_SLT;
          3'b011: if (f7_zero && opc_class == OPC_OP) alu_op = ALU_SLTU;
          3'b100: if (f7_zero && opc_class == OPC_OP) alu_op = ALU_XOR;
          3'b110: if (f7_zero && opc_class == OPC_OP) alu_op = ALU_OR;
          3'b111: if (f7_zero && opc_class == OPC_OP) alu_op = ALU_AND;
          default: alu_op = ALU_NONE;
        endcase
      end
      default: alu_op = ALU_NONE;
    endcase
  end

  // width and signedness of the access
  always_comb begin
    mem_op = MEM_NONE;
    if (opc_class == OPC_LOAD) begin
      case (func3)
        3'b000:  mem_op = MEM_LB;
        3'b001:  mem_op = MEM_LH;
        3'b010:  mem_op = MEM_LW;
        3'b011:  mem_op = MEM_LD;
        3'b100:  mem_op = MEM_LBU;
        3'b101:  mem_op = MEM_LHU;
        3'b110:  mem_op = MEM_LWU;
        default: mem_op = MEM_NONE;
      endcase
    end else if (opc_class == OPC_STORE) begin
      case (func3)
        3'b000:  mem_op = MEM_SB;
        3'b001:  mem_op = MEM_SH;
        3'b010:  mem_op = MEM_SW;
        3'b011:  mem_op = MEM_SD;
        default: mem_op = MEM_NONE;
      endcase
    end
  end

endmodule

// ==== decode_reg.sv ====
`timescale 1ns/1ps

module decode_reg import rv64_decode_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  decoded_t in_dec,
  output logic     out_valid,
  output decoded_t out_dec
);

  // bundle is loaded only on a valid word, held otherwise
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      // all zero reads as none/none/none/inc4
      out_dec   <= '0;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        out_dec <= in_dec;
      end
    end
  end

endmodule

// ==== rv64_decoder.sv ====
`timescale 1ns/1ps
`include "rv64_decode_macros.svh"

module rv64_decoder import rv64_decode_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               inst_valid,
  input  logic [`INST_W-1:0] inst,
  output logic               dec_valid,
  output decoded_t           dec
);

  opc_class_e       opc_class;
  inst_fmt_e        fmt;
  exc_op_e          exc_op;
  pc_op_e           pc_op;
  reg_idx_t         regs;
  logic [`XLEN-1:0] imm;
  alu_op_e          alu_op;
  mem_op_e          mem_op;
  decoded_t         dec_next;

  inst_classify i_classify (
    .inst      (inst),
    .opc_class (opc_class),
    .fmt       (fmt),
    .exc_op    (exc_op),
    .pc_op     (pc_op)
  );

  operand_extract i_operands (
    .inst (inst),
    .fmt  (fmt),
    .regs (regs),
    .imm  (imm)
  );

  op_decode i_op_decode (
    .inst      (inst),
    .opc_class (opc_class),
    .alu_op    (alu_op),
    .mem_op    (mem_op)
  );

  // combinational result packed for the output register
  assign dec_next = '{regs: regs, imm: imm, alu_op: alu_op, mem_op: mem_op,
                      exc_op: exc_op, pc_op: pc_op};

  decode_reg i_decode_reg (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (inst_valid),
    .in_dec    (dec_next),
    .out_valid (dec_valid),
    .out_dec   (dec)
  );

endmodule

// ==== rv64_decoder_properties.sv ====
`timescale 1ns/1ps

module rv64_decoder_properties import rv64_decode_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     inst_valid,
  input logic     dec_valid,
  input decoded_t dec
);

  // output strobe trails the input strobe by one cycle
  a_valid_follows: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) |-> dec_valid == $past(inst_valid))
    else $error("dec_valid does not follow inst_valid");

  a_reset_clears: assert property (@(posedge clk) $past(rst) |-> !dec_valid)
    else $error("dec_valid high after reset");

  // unrecognized words carry no operands
  a_none_is_empty: assert property (@(posedge clk) disable iff (rst)
    (dec_valid && dec.exc_op == EXC_NONE) |-> (dec.regs == '0 && dec.imm == '0))
    else $error("non-zero operands on EXC_NONE bundle");

endmodule

bind rv64_decoder rv64_decoder_properties i_props (
  .clk        (clk),
  .rst        (rst),
  .inst_valid (inst_valid),
  .dec_valid  (dec_valid),
  .dec        (dec)
);

// ==== tb_rv64_decoder.sv ====
`timescale 1ns/1ps
`include "rv64_decode_macros.svh"

module tb_rv64_decoder import rv64_decode_pkg::*; ();

  localparam int RESET_CYCLES = 8;
  localparam int NUM_KEPT     = 400;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_SHIFT    = 80;
  localparam int NUM_SYSTEM   = 30;
  localparam int NUM_GAP      = 200;
  localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_KEPT + NUM_RANDOM + NUM_SHIFT +
                                NUM_SYSTEM + NUM_GAP + 2 + 100;

  logic               clk;
  logic               rst;
  logic               inst_valid;
  logic [`INST_W-1:0] inst;
  logic               dec_valid;
  decoded_t           dec;

  integer   seed = 32'hedcc83c9;
  int       err_count = 0;
  int       cycles = 0;
  logic     exp_valid_q[$];
  decoded_t exp_dec_q[$];
  decoded_t held;

  // the eleven kept major opcodes
  logic [6:0] kept_opc [11] = '{7'h03, 7'h23, 7'h63, 7'h67, 7'h6f, 7'h13,
                                7'h1b, 7'h33, 7'h3b, 7'h17, 7'h37};
  logic [6:0] f7_list [6] = '{7'h00, 7'h20, 7'h01, 7'h21, 7'h40, 7'h02};
  logic [6:0] arith_opc [4] = '{7'h13, 7'h1b, 7'h33, 7'h3b};
  logic [2:0] shift_f3 [3] = '{3'd0, 3'd1, 3'd5};

  rv64_decoder i_dut (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .inst       (inst),
    .dec_valid  (dec_valid),
    .dec        (dec)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // reference model of the decode rules
  function automatic alu_op_e model_alu(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic [6:0] f7);
    alu_op_e a;
    logic    is_imm;
    logic    is_word;
    is_imm  = (opc == 7'h13) || (opc == 7'h1b);
    is_word = (opc == 7'h1b) || (opc == 7'h3b);
    a = ALU_NONE;
    case (f3)
      3'd0: begin
        if (is_imm) a = ALU_ADD;
        else if (f7 == 7'h00) a = ALU_ADD;
        else if (f7 == 7'h20) a = ALU_SUB;
      end
      3'd1: begin
        if (opc == 7'h13) a = (f7[6:1] == 6'h00) ? ALU_SLL : ALU_NONE;
        else if (f7 == 7'h00) a = ALU_SLL;
      end
      3'd5: begin
        if (opc == 7'h13) begin
          if (f7[6:1] == 6'h00) a = ALU_SRL;
          else if (f7[6:1] == 6'h10) a = ALU_SRA;
        end else if (f7 == 7'h00) a = ALU_SRL;
        else if (f7 == 7'h20) a = ALU_SRA;
      end
      default: begin
        if (!is_word && (is_imm || f7 == 7'h00)) begin
          case (f3)
            3'd2: a = ALU_SLT;
            3'd3: a = ALU_SLTU;
            3'd4: a = ALU_XOR;
            3'd6: a = ALU_OR;
            default: a = ALU_AND;
          endcase
        end
      end
    endcase
    return a;
  endfunction

  function automatic decoded_t model_decode(input logic [31:0] w);
    decoded_t  d;
    inst_fmt_e fmt;
    logic [2:0] f3;
    f3  = w[14:12];
    d   = '0;
    fmt = FMT_NONE;
    case (w[6:0])
      7'h03: begin
        fmt = FMT_I; d.exc_op = EXC_LOAD; d.alu_op = ALU_ADD;
        case (f3)
          3'd0: d.mem_op = MEM_LB;
          3'd1: d.mem_op = MEM_LH;
          3'd2: d.mem_op = MEM_LW;
          3'd3: d.mem_op = MEM_LD;
          3'd4: d.mem_op = MEM_LBU;
          3'd5: d.mem_op = MEM_LHU;
          3'd6: d.mem_op = MEM_LWU;
          default: d.mem_op = MEM_NONE;
        endcase
      end
      7'h23: begin
        fmt = FMT_S; d.exc_op = EXC_STORE; d.alu_op = ALU_ADD;
        case (f3)
          3'd0: d.mem_op = MEM_SB;
          3'd1: d.mem_op = MEM_SH;
          3'd2: d.mem_op = MEM_SW;
          3'd3: d.mem_op = MEM_SD;
          default: d.mem_op = MEM_NONE;
        endcase
      end
      7'h63: begin
        fmt = FMT_B; d.exc_op = EXC_BRANCH; d.pc_op = PC_BRANCH;
        case (f3)
          3'd0: d.alu_op = ALU_BEQ;
          3'd1: d.alu_op = ALU_BNE;
          3'd4: d.alu_op = ALU_BLT;
          3'd5: d.alu_op = ALU_BGE;
          3'd6: d.alu_op = ALU_BLTU;
          3'd7: d.alu_op = ALU_BGEU;
          default: d.alu_op = ALU_NONE;
        endcase
      end
      7'h67: begin
        fmt = FMT_I; d.exc_op = EXC_JALR; d.pc_op = PC_JALR;
        d.alu_op = (f3 == 3'd0) ? ALU_ADD : ALU_NONE;
      end
      7'h6f: begin
        fmt = FMT_J; d.exc_op = EXC_JAL; d.pc_op = PC_JAL; d.alu_op = ALU_ADD;
      end
      7'h13: begin
        fmt = FMT_I; d.exc_op = EXC_OPIMM; d.alu_op = model_alu(w[6:0], f3, w[31:25]);
      end
      7'h1b: begin
        fmt = FMT_I; d.exc_op = EXC_OPIMM32; d.alu_op = model_alu(w[6:0], f3, w[31:25]);
      end
      7'h33: begin
        fmt = FMT_R; d.exc_op = EXC_OP; d.alu_op = model_alu(w[6:0], f3, w[31:25]);
      end
      7'h3b: begin
        fmt = FMT_R; d.exc_op = EXC_OP32; d.alu_op = model_alu(w[6:0], f3, w[31:25]);
      end
      7'h17: begin
        fmt = FMT_U; d.exc_op = EXC_AUIPC; d.alu_op = ALU_ADD;
      end
      7'h37: begin
        fmt = FMT_U; d.exc_op = EXC_LUI;
      end
      7'h73: begin
        if (f3 == 3'd0 && w[31:20] == 12'd1) d.exc_op = EXC_EBREAK;
      end
      default: ;
    endcase
    if (fmt inside {FMT_R, FMT_I, FMT_S, FMT_B}) d.regs.rs1 = w[19:15];
    if (fmt inside {FMT_R, FMT_S, FMT_B}) d.regs.rs2 = w[24:20];
    if (fmt inside {FMT_R, FMT_I, FMT_U, FMT_J}) d.regs.rd = w[11:7];
    case (fmt)
      FMT_I: d.imm = {{(`XLEN-12){w[31]}}, w[31:20]};
      FMT_S: d.imm = {{(`XLEN-12){w[31]}}, w[31:25], w[11:7]};
      FMT_B: d.imm = {{(`XLEN-13){w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      FMT_U: d.imm = {{(`XLEN-32){w[31]}}, w[31:12], 12'b0};
      FMT_J: d.imm = {{(`XLEN-21){w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  task automatic check_val(input string name, input logic [`XLEN-1:0] exp_v,
                           input logic [`XLEN-1:0] act_v);
    if (exp_v !== act_v) begin
      err_count++;
      $display("FAILED %s expected %0h actual %0h", name, exp_v, act_v);
    end
  endtask

  task automatic compare_bundle(input string name, input logic ev, input decoded_t ed);
    check_val({name, " dec_valid"}, ev, dec_valid);
    check_val({name, " regs"}, ed.regs, dec.regs);
    check_val({name, " imm"}, ed.imm, dec.imm);
    check_val({name, " alu_op"}, ed.alu_op, dec.alu_op);
    check_val({name, " mem_op"}, ed.mem_op, dec.mem_op);
    check_val({name, " exc_op"}, ed.exc_op, dec.exc_op);
    check_val({name, " pc_op"}, ed.pc_op, dec.pc_op);
  endtask

  // drive one word, then check the word sent one cycle earlier
  task automatic send_word(input string name, input logic v, input logic [31:0] w);
    logic     ev;
    decoded_t ed;
    @(posedge clk);
    inst_valid <= v;
    inst       <= w;
    @(negedge clk);
    if (exp_valid_q.size() == 0) begin
      err_count++;
      $display("expected-value queue ran empty in %s", name);
    end else begin
      ev = exp_valid_q.pop_front();
      ed = exp_dec_q.pop_front();
      if (ev) held = ed;
      compare_bundle(name, ev, held);
    end
    exp_valid_q.push_back(v);
    exp_dec_q.push_back(model_decode(w));
  endtask

  function automatic logic [31:0] kept_word();
    logic [31:0] w;
    w = $random(seed);
    w[6:0] = kept_opc[{$random(seed)} % 11];
    return w;
  endfunction

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [31:0] w;
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    held       = '0;
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
      @(negedge clk);
      compare_bundle("reset", 1'b0, '0);
    end
    @(posedge clk);
    rst <= 1'b0;
    exp_valid_q.push_back(1'b0);
    exp_dec_q.push_back('0);

    for (int i = 0; i < NUM_KEPT; i++) send_word("kept_class", 1'b1, kept_word());
    for (int i = 0; i < NUM_RANDOM; i++) send_word("random_word", 1'b1, $random(seed));

    for (int i = 0; i < NUM_SHIFT; i++) begin
      w = $random(seed);
      w[6:0]   = arith_opc[{$random(seed)} % 4];
      w[14:12] = shift_f3[{$random(seed)} % 3];
      w[31:25] = f7_list[{$random(seed)} % 6];
      send_word("shift_func7", 1'b1, w);
    end

    for (int i = 0; i < NUM_SYSTEM; i++) begin
      w = $random(seed);
      w[6:0] = 7'h73;
      case (i % 3)
        0: w[31:20] = 12'd1;
        1: w = 32'h0000_0073;
        default: ;
      endcase
      if (i % 3 == 0) w[14:12] = 3'd0;
      send_word("system", 1'b1, w);
    end

    // output must hold the last valid bundle across random bubbles
    for (int i = 0; i < NUM_GAP; i++) begin
      send_word("valid_gap", ({$random(seed)} % 4) != 0, kept_word());
    end
    send_word("flush", 1'b0, $random(seed));

    $display("checks done, error count %0d", err_count);
    if (err_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
rv64_decode_pkg.sv
inst_classify.sv
operand_extract.sv
op_decode.sv
decode_reg.sv
rv64_decoder.sv
rv64_decoder_properties.sv
tb_rv64_decoder.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_rv64_decoder -o sim_rv64
./obj_dir/sim_rv64 > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
  exit 1
fi
exit 0
